/* design/cpu_pkg.sv */
// The ISA fixes the word width at 16 and the cpu top level sets the memory address width
package cpu_pkg;

   localparam int DATA_WIDTH = 16;
   localparam int REG_IDX_WIDTH = 3;

   typedef logic [DATA_WIDTH-1:0] word_t;
   typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;

   // Major opcode in bits 15 to 13
   typedef enum logic [2:0] {
      OPC_LDR  = 3'b011,
      OPC_STR  = 3'b100,
      OPC_ALU  = 3'b101,
      OPC_MOV  = 3'b110,
      OPC_HALT = 3'b111
   } opcode_e;

   // Op field in bits 12 to 11 for ALU instructions
   typedef enum logic [1:0] {
      ALU_ADD = 2'b00,
      ALU_CMP = 2'b01,
      ALU_AND = 2'b10,
      ALU_MVN = 2'b11
   } alu_op_e;

   // Op field values that pick the MOV form
   localparam logic [1:0] MOV_IMM = 2'b10;
   localparam logic [1:0] MOV_REG = 2'b00;

   typedef enum logic [1:0] {
      SHIFT_NONE = 2'b00,
      SHIFT_LSL  = 2'b01,
      SHIFT_LSR  = 2'b10,
      SHIFT_ASR  = 2'b11
   } shift_e;

   typedef enum logic [1:0] {
      NSEL_RM = 2'b00,
      NSEL_RD = 2'b01,
      NSEL_RN = 2'b10
   } nsel_e;

   // 2'b01 was the PC source and stays unused
   typedef enum logic [1:0] {
      VSEL_C     = 2'b00,
      VSEL_IMM   = 2'b10,
      VSEL_MDATA = 2'b11
   } vsel_e;

   typedef enum logic [1:0] {
      MWRITE = 2'b00,
      MREAD  = 2'b01
   } mem_cmd_e;

   typedef enum logic [4:0] {
      RESET, IF1, IF2, UPDATE_PC, DECODE,
      GET_A, GET_B, GET_B_RD,
      ADD, AND_OP, NOT_OP, PASS,
      WRITE_REG, WRITE_IMM, ADD_IMM,
      WRITE_DATA_ADDR, LOAD_WAIT, REG_FROM_MEM, REG_TO_MEM,
      HALT
   } state_e;

endpackage

/* design/cpu_ifs.sv */
// Internal control and decode bundles only, no clock is carried and all signals are level
`timescale 1ns/100ps

// Register file and ALU strobes from the controller
interface datapath_ctrl_if;
   cpu_pkg::nsel_e nsel;
   logic           loada;
   logic           loadb;
   logic           loadc;
   logic           asel;
   logic           bsel;
   cpu_pkg::vsel_e vsel;
   logic           write;

   modport controller (
      output nsel, loada, loadb, loadc, asel, bsel, vsel, write
   );
   modport datapath (
      input nsel, loada, loadb, loadc, asel, bsel, vsel, write
   );
endinterface

// PC, IR and data address strobes
interface addr_ctrl_if;
   logic load_pc;
   logic reset_pc;
   logic load_ir;
   logic load_addr;
   logic addr_sel;

   modport controller (
      output load_pc, reset_pc, load_ir, load_addr, addr_sel
   );
   modport addr_unit (
      input load_pc, reset_pc, load_ir, load_addr, addr_sel
   );
endinterface

// Instruction fields after decode
interface decoded_if;
   cpu_pkg::opcode_e  opcode;
   logic [1:0]        op;
   cpu_pkg::reg_idx_t rn;
   cpu_pkg::reg_idx_t rd;
   cpu_pkg::reg_idx_t rm;
   cpu_pkg::shift_e   shift;
   cpu_pkg::alu_op_e  alu_op;
   cpu_pkg::word_t    sximm5;
   cpu_pkg::word_t    sximm8;

   modport decoder (
      output opcode, op, rn, rd, rm, shift, alu_op, sximm5, sximm8
   );
   modport controller (
      input opcode, op
   );
   modport datapath (
      input rn, rd, rm, shift, alu_op, sximm5, sximm8
   );
endinterface

/* design/register_file.sv */
// Single index shared by the read and write ports, so a write and its readback use the same register
`timescale 1ns/100ps

module register_file (
   input  logic              clk,
   input  logic              write,
   input  cpu_pkg::reg_idx_t index,
   input  cpu_pkg::word_t    write_data,
   output cpu_pkg::word_t    read_data
);

   cpu_pkg::word_t regs [2**cpu_pkg::REG_IDX_WIDTH];

   always_ff @(posedge clk) begin
      if (write) begin
         regs[index] <= write_data;
      end
   end

   // Read is combinational and shows the old value during a write
   assign read_data = regs[index];

endmodule

/* design/datapath.sv */
// A, B and C have no reset, so they hold unknowns until the first instruction loads them
`timescale 1ns/100ps

module datapath (
   input  logic              clk,
   datapath_ctrl_if.datapath dp,
   decoded_if.datapath       dec,
   input  cpu_pkg::word_t    mdata,
   output cpu_pkg::word_t    c_value
);

   cpu_pkg::reg_idx_t reg_index;
   cpu_pkg::word_t    rf_read;
   cpu_pkg::word_t    rf_write;
   cpu_pkg::word_t    a_reg;
   cpu_pkg::word_t    b_reg;
   cpu_pkg::word_t    b_shifted;
   cpu_pkg::word_t    a_operand;
   cpu_pkg::word_t    b_operand;
   cpu_pkg::word_t    alu_out;

   always_comb begin
      case (dp.nsel)
         cpu_pkg::NSEL_RN: reg_index = dec.rn;
         cpu_pkg::NSEL_RD: reg_index = dec.rd;
         default:          reg_index = dec.rm;
      endcase
      case (dp.vsel)
         cpu_pkg::VSEL_IMM:   rf_write = dec.sximm8;
         cpu_pkg::VSEL_MDATA: rf_write = mdata;
         default:             rf_write = c_value;
      endcase
   end

   register_file u_regs (
      .clk        (clk),
      .write      (dp.write),
      .index      (reg_index),
      .write_data (rf_write),
      .read_data  (rf_read)
   );

   always_ff @(posedge clk) begin
      if (dp.loada) begin
         a_reg <= rf_read;
      end
      if (dp.loadb) begin
         b_reg <= rf_read;
      end
      if (dp.loadc) begin
         c_value <= alu_out;
      end
   end

   // Shifter sits on the B output
   always_comb begin
      case (dec.shift)
         cpu_pkg::SHIFT_LSL: b_shifted = {b_reg[cpu_pkg::DATA_WIDTH-2:0], 1'b0};
         cpu_pkg::SHIFT_LSR: b_shifted = {1'b0, b_reg[cpu_pkg::DATA_WIDTH-1:1]};
         cpu_pkg::SHIFT_ASR: b_shifted = {b_reg[cpu_pkg::DATA_WIDTH-1],
                                          b_reg[cpu_pkg::DATA_WIDTH-1:1]};
         default:            b_shifted = b_reg;
      endcase
      a_operand = dp.asel ? '0 : a_reg;
      b_operand = dp.bsel ? dec.sximm5 : b_shifted;
      case (dec.alu_op)
         cpu_pkg::ALU_AND: alu_out = a_operand & b_operand;
         cpu_pkg::ALU_MVN: alu_out = ~b_operand;
         default:          alu_out = a_operand + b_operand;
      endcase
   end

   a_vsel_legal: assert property (@(posedge clk)
      dp.write |-> dp.vsel inside {cpu_pkg::VSEL_C, cpu_pkg::VSEL_IMM, cpu_pkg::VSEL_MDATA});

endmodule

/* design/instruction_decoder.sv */
// Purely combinational, decodes whatever the instruction register holds including unused opcodes
`timescale 1ns/100ps

module instruction_decoder (
   input  cpu_pkg::word_t instruction,
   decoded_if.decoder     dec
);

   always_comb begin
      dec.opcode = cpu_pkg::opcode_e'(instruction[15:13]);
      dec.op     = instruction[12:11];
      dec.rn     = instruction[10:8];
      dec.rd     = instruction[7:5];
      dec.rm     = instruction[2:0];
      dec.sximm5 = {{(cpu_pkg::DATA_WIDTH-5){instruction[4]}}, instruction[4:0]};
      dec.sximm8 = {{(cpu_pkg::DATA_WIDTH-8){instruction[7]}}, instruction[7:0]};

      // Bits 4 to 3 belong to imm5 in loads and stores
      if (dec.opcode == cpu_pkg::OPC_LDR || dec.opcode == cpu_pkg::OPC_STR) begin
         dec.shift = cpu_pkg::SHIFT_NONE;
      end else begin
         dec.shift = cpu_pkg::shift_e'(instruction[4:3]);
      end

      // Everything outside the ALU group needs a plain add
      if (dec.opcode == cpu_pkg::OPC_ALU) begin
         dec.alu_op = cpu_pkg::alu_op_e'(dec.op);
      end else begin
         dec.alu_op = cpu_pkg::ALU_ADD;
      end
   end

endmodule

/* design/address_unit.sv */
// ADDR_WIDTH must not exceed the word width, and the PC wraps at the top of memory
`timescale 1ns/100ps

module address_unit #(
   parameter int ADDR_WIDTH = 9
) (
   input  logic                  clk,
   addr_ctrl_if.addr_unit        ac,
   input  cpu_pkg::word_t        read_data,
   input  cpu_pkg::word_t        c_value,
   output cpu_pkg::word_t        instruction,
   output logic [ADDR_WIDTH-1:0] mem_addr
);

   logic [ADDR_WIDTH-1:0] pc;
   logic [ADDR_WIDTH-1:0] data_addr;

   // Cleared by the controller through reset_pc
   always_ff @(posedge clk) begin
      if (ac.load_pc) begin
         pc <= ac.reset_pc ? '0 : pc + 1'b1;
      end
      if (ac.load_ir) begin
         instruction <= read_data;
      end
      if (ac.load_addr) begin
         data_addr <= c_value[ADDR_WIDTH-1:0];
      end
   end

   assign mem_addr = ac.addr_sel ? pc : data_addr;

   // Clearing the PC only takes effect together with a load
   a_reset_with_load: assert property (@(posedge clk)
      ac.reset_pc |-> ac.load_pc);

endmodule

/* design/cpu_controller.sv */
// One state per cycle, CMP and branch encodings halt and only reset leaves the halt state
`timescale 1ns/100ps

module cpu_controller (
   input  logic                  clk,
   input  logic                  reset,
   decoded_if.controller         dec,
   datapath_ctrl_if.controller   dp,
   addr_ctrl_if.controller       ac,
   output cpu_pkg::mem_cmd_e     mem_cmd,
   output logic                  halt
);

   cpu_pkg::state_e state;
   cpu_pkg::state_e next_state;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= cpu_pkg::RESET;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = cpu_pkg::HALT;
      case (state)
         cpu_pkg::RESET:     next_state = cpu_pkg::IF1;
         cpu_pkg::IF1:       next_state = cpu_pkg::IF2;
         cpu_pkg::IF2:       next_state = cpu_pkg::UPDATE_PC;
         cpu_pkg::UPDATE_PC: next_state = cpu_pkg::DECODE;
         cpu_pkg::DECODE: begin
            case (dec.opcode)
               cpu_pkg::OPC_MOV: begin
                  if (dec.op == cpu_pkg::MOV_IMM) begin
                     next_state = cpu_pkg::WRITE_IMM;
                  end else if (dec.op == cpu_pkg::MOV_REG) begin
                     next_state = cpu_pkg::GET_B;
                  end
               end
               cpu_pkg::OPC_ALU: begin
                  case (dec.op)
                     cpu_pkg::ALU_ADD, cpu_pkg::ALU_AND: next_state = cpu_pkg::GET_A;
                     cpu_pkg::ALU_MVN: next_state = cpu_pkg::GET_B;
                     cpu_pkg::ALU_CMP: next_state = cpu_pkg::HALT;
                     default:          next_state = cpu_pkg::HALT;
                  endcase
               end
               cpu_pkg::OPC_LDR, cpu_pkg::OPC_STR: begin
                  if (dec.op == 2'b00) begin
                     next_state = cpu_pkg::GET_A;
                  end
               end
               default: next_state = cpu_pkg::HALT;
            endcase
         end
         cpu_pkg::GET_A: begin
            if (dec.opcode == cpu_pkg::OPC_LDR || dec.opcode == cpu_pkg::OPC_STR) begin
               next_state = cpu_pkg::ADD_IMM;
            end else begin
               next_state = cpu_pkg::GET_B;
            end
         end
         cpu_pkg::GET_B: begin
            if (dec.opcode == cpu_pkg::OPC_MOV) begin
               next_state = cpu_pkg::PASS;
            end else begin
               case (dec.op)
                  cpu_pkg::ALU_ADD: next_state = cpu_pkg::ADD;
                  cpu_pkg::ALU_AND: next_state = cpu_pkg::AND_OP;
                  cpu_pkg::ALU_MVN: next_state = cpu_pkg::NOT_OP;
                  default:          next_state = cpu_pkg::HALT;
               endcase
            end
         end
         cpu_pkg::ADD, cpu_pkg::AND_OP, cpu_pkg::NOT_OP: next_state = cpu_pkg::WRITE_REG;
         cpu_pkg::PASS: begin
            if (dec.opcode == cpu_pkg::OPC_STR) begin
               next_state = cpu_pkg::REG_TO_MEM;
            end else begin
               next_state = cpu_pkg::WRITE_REG;
            end
         end
         cpu_pkg::ADD_IMM: next_state = cpu_pkg::WRITE_DATA_ADDR;
         cpu_pkg::WRITE_DATA_ADDR: begin
            if (dec.opcode == cpu_pkg::OPC_LDR) begin
               next_state = cpu_pkg::LOAD_WAIT;
            end else begin
               next_state = cpu_pkg::GET_B_RD;
            end
         end
         cpu_pkg::LOAD_WAIT: next_state = cpu_pkg::REG_FROM_MEM;
         cpu_pkg::GET_B_RD:  next_state = cpu_pkg::PASS;
         cpu_pkg::WRITE_REG, cpu_pkg::WRITE_IMM,
         cpu_pkg::REG_FROM_MEM, cpu_pkg::REG_TO_MEM: next_state = cpu_pkg::IF1;
         default: next_state = cpu_pkg::HALT;
      endcase
   end

   // Everything idles and the PC drives the address unless a state says otherwise
   always_comb begin
      dp.nsel      = cpu_pkg::NSEL_RM;
      dp.loada     = 1'b0;
      dp.loadb     = 1'b0;
      dp.loadc     = 1'b0;
      dp.asel      = 1'b0;
      dp.bsel      = 1'b0;
      dp.vsel      = cpu_pkg::VSEL_C;
      dp.write     = 1'b0;
      ac.load_pc   = 1'b0;
      ac.reset_pc  = 1'b0;
      ac.load_ir   = 1'b0;
      ac.load_addr = 1'b0;
      ac.addr_sel  = 1'b1;
      mem_cmd      = cpu_pkg::MREAD;
      halt         = 1'b0;
      case (state)
         cpu_pkg::RESET: begin
            ac.load_pc  = 1'b1;
            ac.reset_pc = 1'b1;
         end
         cpu_pkg::IF2:       ac.load_ir = 1'b1;
         cpu_pkg::UPDATE_PC: ac.load_pc = 1'b1;
         cpu_pkg::GET_A: begin
            dp.nsel  = cpu_pkg::NSEL_RN;
            dp.loada = 1'b1;
         end
         cpu_pkg::GET_B:  dp.loadb = 1'b1;
         cpu_pkg::GET_B_RD: begin
            dp.nsel  = cpu_pkg::NSEL_RD;
            dp.loadb = 1'b1;
         end
         cpu_pkg::ADD, cpu_pkg::AND_OP, cpu_pkg::NOT_OP: dp.loadc = 1'b1;
         // A is zeroed so the shifted B passes through
         cpu_pkg::PASS: begin
            dp.asel  = 1'b1;
            dp.loadc = 1'b1;
         end
         cpu_pkg::ADD_IMM: begin
            dp.bsel  = 1'b1;
            dp.loadc = 1'b1;
         end
         cpu_pkg::WRITE_REG: begin
            dp.nsel  = cpu_pkg::NSEL_RD;
            dp.write = 1'b1;
         end
         cpu_pkg::WRITE_IMM: begin
            dp.nsel  = cpu_pkg::NSEL_RN;
            dp.vsel  = cpu_pkg::VSEL_IMM;
            dp.write = 1'b1;
         end
         cpu_pkg::WRITE_DATA_ADDR: ac.load_addr = 1'b1;
         cpu_pkg::LOAD_WAIT:       ac.addr_sel  = 1'b0;
         cpu_pkg::REG_FROM_MEM: begin
            ac.addr_sel = 1'b0;
            dp.nsel     = cpu_pkg::NSEL_RD;
            dp.vsel     = cpu_pkg::VSEL_MDATA;
            dp.write    = 1'b1;
         end
         cpu_pkg::REG_TO_MEM: begin
            ac.addr_sel = 1'b0;
            mem_cmd     = cpu_pkg::MWRITE;
         end
         cpu_pkg::HALT: halt = 1'b1;
         default: ;
      endcase
   end

   // A write only follows the PASS state of a store
   a_write_in_store: assert property (@(posedge clk) disable iff (reset)
      mem_cmd == cpu_pkg::MWRITE |->
         $past(state) == cpu_pkg::PASS && dec.opcode == cpu_pkg::OPC_STR);

   a_halt_sticky: assert property (@(posedge clk) disable iff (reset)
      halt |=> halt);

   // The PC steps only right after an instruction load and never in the same cycle
   a_ir_pc_exclusive: assert property (@(posedge clk) disable iff (reset)
      ac.load_pc |-> !ac.load_ir && (ac.reset_pc || $past(ac.load_ir)));

endmodule

/* design/cpu.sv */
// Memory must return read data one clock after the address and has no handshake
`timescale 1ns/100ps

module cpu #(
   parameter int ADDR_WIDTH = 9
) (
   input  logic              clk,
   input  logic              reset,
   input  cpu_pkg::word_t    read_data,
   output cpu_pkg::mem_cmd_e mem_cmd,
   output logic [ADDR_WIDTH-1:0] mem_addr,
   output cpu_pkg::word_t    write_data,
   output logic              halt
);

   cpu_pkg::word_t instruction;

   datapath_ctrl_if dp_ctrl ();
   addr_ctrl_if     addr_ctrl ();
   decoded_if       dec ();

   cpu_controller u_controller (
      .clk     (clk),
      .reset   (reset),
      .dec     (dec),
      .dp      (dp_ctrl),
      .ac      (addr_ctrl),
      .mem_cmd (mem_cmd),
      .halt    (halt)
   );

   instruction_decoder u_decoder (
      .instruction (instruction),
      .dec         (dec)
   );

   address_unit #(
      .ADDR_WIDTH (ADDR_WIDTH)
   ) u_address_unit (
      .clk         (clk),
      .ac          (addr_ctrl),
      .read_data   (read_data),
      .c_value     (write_data),
      .instruction (instruction),
      .mem_addr    (mem_addr)
   );

   // Stores always write the C register
   datapath u_datapath (
      .clk     (clk),
      .dp      (dp_ctrl),
      .dec     (dec),
      .mdata   (read_data),
      .c_value (write_data)
   );

endmodule

/* verification/tb_cpu.sv */
// Memory answers reads one cycle late, data words sit at 111 to 142 above a program of up to 70 words
`timescale 1ns/100ps

module tb_cpu;

   localparam int ADDR_WIDTH = 9;
   localparam int MEM_WORDS = 512;
   localparam int CLK_PERIOD = 10;
   localparam int DRIVE_DELAY = 1;
   localparam int RANDOM_INSTRS = 60;
   localparam int PROGRAMS = 2;
   localparam int MAX_INSTRS = 70;
   localparam int MAX_CYCLES = 10;
   localparam int WATCHDOG_NS = PROGRAMS * MAX_INSTRS * MAX_CYCLES * CLK_PERIOD * 2;
   localparam int HALT_HOLD = 20;

   // ISA opcodes
   localparam logic [2:0] OP_LDR = 3'b011;
   localparam logic [2:0] OP_STR = 3'b100;
   localparam logic [2:0] OP_ALU = 3'b101;
   localparam logic [2:0] OP_MOV = 3'b110;
   localparam logic [2:0] OP_HALT = 3'b111;
   localparam logic [2:0] OP_BRANCH = 3'b001;

   logic                  clk;
   logic                  reset;
   cpu_pkg::word_t        read_data;
   cpu_pkg::mem_cmd_e     mem_cmd;
   logic [ADDR_WIDTH-1:0] mem_addr;
   cpu_pkg::word_t        write_data;
   logic                  halt;

   cpu_pkg::word_t mem [MEM_WORDS];
   cpu_pkg::word_t program_words [$];
   cpu_pkg::word_t exp_addr [$];
   cpu_pkg::word_t exp_data [$];
   int             exp_count;
   int             write_count;
   int             seed;
   string          test_name;

   // Bus values captured at the falling edge
   cpu_pkg::mem_cmd_e     cmd_q;
   logic [ADDR_WIDTH-1:0] addr_q;
   cpu_pkg::word_t        wdata_q;
   logic                  reset_q;

   cpu dut0 (
      .clk        (clk),
      .reset      (reset),
      .read_data  (read_data),
      .mem_cmd    (mem_cmd),
      .mem_addr   (mem_addr),
      .write_data (write_data),
      .halt       (halt)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic stop_on_failure();
      $display("Test failures found");
      $fatal(1, "stopping at the first failure");
   endtask

   task automatic check_value(input string what, input cpu_pkg::word_t expected,
                              input cpu_pkg::word_t actual);
      if (actual !== expected) begin
         $display("Error in %s, %s: expected 0x%04h, actual 0x%04h",
                  test_name, what, expected, actual);
         stop_on_failure();
      end
   endtask

   function automatic int rand_below(input int n);
      int r;
      r = $random(seed);
      return (r & 32'h7fff_ffff) % n;
   endfunction

   function automatic cpu_pkg::word_t encode(input logic [2:0] opc, input logic [1:0] op,
                                             input logic [2:0] rn, input logic [7:0] low);
      return {opc, op, rn, low};
   endfunction

   function automatic cpu_pkg::word_t fill_word(input int addr);
      return 16'(addr * 40503) ^ 16'h3C5A;
   endfunction

   function automatic cpu_pkg::word_t shift_value(input cpu_pkg::word_t value,
                                                  input logic [1:0] code);
      case (code)
         2'b01:   return {value[14:0], 1'b0};
         2'b10:   return {1'b0, value[15:1]};
         2'b11:   return {value[15], value[15:1]};
         default: return value;
      endcase
   endfunction

   function automatic cpu_pkg::reg_idx_t pick_source(input logic [7:0] written);
      cpu_pkg::reg_idx_t idx;
      idx = 3'(rand_below(8));
      while (!written[idx]) begin
         idx = 3'(rand_below(8));
      end
      return idx;
   endfunction

   // Unwritten registers are filled first so nothing reads an unknown value
   function automatic cpu_pkg::reg_idx_t pick_dest(input logic [7:0] written);
      for (int i = 0; i < 7; i++) begin
         if (!written[i]) begin
            return 3'(i);
         end
      end
      return 3'(rand_below(7));
   endfunction

   task automatic build_random_program();
      logic [7:0]        written;
      logic [4:0]        off;
      logic [4:0]        last_off;
      bit                stored;
      bit                round_trip;
      int                kind;
      cpu_pkg::reg_idx_t rd;
      cpu_pkg::reg_idx_t rn;
      cpu_pkg::reg_idx_t rm;
      logic [1:0]        sh;
      program_words.delete();
      program_words.push_back(encode(OP_MOV, 2'b10, 3'd7, 8'd127));
      written = 8'h80;
      last_off = '0;
      stored = 1'b0;
      round_trip = 1'b0;
      for (int i = 0; i < RANDOM_INSTRS; i++) begin
         kind = (written[6:0] != 7'h7f) ? rand_below(6) : rand_below(7);
         // Last two slots force a store and a load of the same word
         if (!round_trip && i == RANDOM_INSTRS - 2) begin
            kind = 6;
         end
         if (!round_trip && i == RANDOM_INSTRS - 1) begin
            kind = 5;
         end
         rn = pick_source(written);
         rm = pick_source(written);
         rd = pick_dest(written);
         sh = 2'(rand_below(4));
         off = 5'(rand_below(32));
         case (kind)
            0: program_words.push_back(encode(OP_MOV, 2'b10, rd, 8'(rand_below(256))));
            1: program_words.push_back(encode(OP_MOV, 2'b00, 3'd0, {rd, sh, rm}));
            2: program_words.push_back(encode(OP_ALU, 2'b00, rn, {rd, sh, rm}));
            3: program_words.push_back(encode(OP_ALU, 2'b10, rn, {rd, sh, rm}));
            4: program_words.push_back(encode(OP_ALU, 2'b11, rn, {rd, sh, rm}));
            5: begin
               if (stored && (i == RANDOM_INSTRS - 1 || rand_below(2) == 0)) begin
                  off = last_off;
                  round_trip = 1'b1;
               end
               program_words.push_back(encode(OP_LDR, 2'b00, 3'd7, {rd, off}));
            end
            default: begin
               program_words.push_back(encode(OP_STR, 2'b00, 3'd7, {rm, off}));
               last_off = off;
               stored = 1'b1;
            end
         endcase
         if (kind != 6) begin
            written[rd] = 1'b1;
         end
      end
      for (int r = 0; r < 7; r++) begin
         program_words.push_back(encode(OP_STR, 2'b00, 3'd7, {3'(r), 5'(r)}));
      end
      program_words.push_back(encode(OP_HALT, 2'b00, 3'd0, 8'd0));
   endtask

   task automatic build_halt_program();
      program_words.delete();
      program_words.push_back(encode(OP_MOV, 2'b10, 3'd7, 8'd127));
      program_words.push_back(encode(OP_STR, 2'b00, 3'd7, {3'd7, 5'd1}));
      program_words.push_back(encode(OP_STR, 2'b00, 3'd7, {3'd7, 5'd2}));
      // Branch opcode is outside the kept ISA
      program_words.push_back(encode(OP_BRANCH, 2'b00, 3'd0, 8'd2));
      program_words.push_back(encode(OP_STR, 2'b00, 3'd7, {3'd7, 5'd3}));
      program_words.push_back(encode(OP_STR, 2'b00, 3'd7, {3'd7, 5'd4}));
      program_words.push_back(encode(OP_HALT, 2'b00, 3'd0, 8'd0));
   endtask

   // Instruction-level model, runs on a copy of the loaded memory image
   task automatic run_model(output int round_trips);
      cpu_pkg::word_t        regs [8];
      cpu_pkg::word_t        model_mem [MEM_WORDS];
      bit                    stored_at [MEM_WORDS];
      cpu_pkg::word_t        ins;
      cpu_pkg::word_t        b_val;
      cpu_pkg::word_t        sum;
      logic [ADDR_WIDTH-1:0] addr;
      logic [ADDR_WIDTH-1:0] pc;
      bit                    halted;
      int                    steps;
      for (int i = 0; i < MEM_WORDS; i++) begin
         model_mem[i] = mem[i];
         stored_at[i] = 1'b0;
      end
      for (int i = 0; i < 8; i++) begin
         regs[i] = '0;
      end
      exp_addr.delete();
      exp_data.delete();
      round_trips = 0;
      pc = '0;
      halted = 1'b0;
      steps = 0;
      while (!halted && steps < MAX_INSTRS) begin
         ins = model_mem[pc];
         pc = pc + 9'd1;
         steps++;
         b_val = shift_value(regs[ins[2:0]], ins[4:3]);
         sum = regs[ins[10:8]] + {{11{ins[4]}}, ins[4:0]};
         addr = sum[ADDR_WIDTH-1:0];
         case (ins[15:13])
            OP_MOV: begin
               if (ins[12:11] == 2'b10) begin
                  regs[ins[10:8]] = {{8{ins[7]}}, ins[7:0]};
               end else if (ins[12:11] == 2'b00) begin
                  regs[ins[7:5]] = b_val;
               end else begin
                  halted = 1'b1;
               end
            end
            OP_ALU: begin
               case (ins[12:11])
                  2'b00:   regs[ins[7:5]] = regs[ins[10:8]] + b_val;
                  2'b10:   regs[ins[7:5]] = regs[ins[10:8]] & b_val;
                  2'b11:   regs[ins[7:5]] = ~b_val;
                  default: halted = 1'b1;
               endcase
            end
            OP_LDR: begin
               if (ins[12:11] != 2'b00) begin
                  halted = 1'b1;
               end else begin
                  if (stored_at[addr]) begin
                     round_trips++;
                  end
                  regs[ins[7:5]] = model_mem[addr];
               end
            end
            OP_STR: begin
               if (ins[12:11] != 2'b00) begin
                  halted = 1'b1;
               end else begin
                  model_mem[addr] = regs[ins[7:5]];
                  stored_at[addr] = 1'b1;
                  exp_addr.push_back(16'(addr));
                  exp_data.push_back(regs[ins[7:5]]);
               end
            end
            default: halted = 1'b1;
         endcase
      end
      exp_count = exp_addr.size();
      if (!halted) begin
         $display("The reference model never reached a halt in %s", test_name);
         stop_on_failure();
      end
   endtask

   initial begin
      cmd_q = cpu_pkg::MREAD;
      reset_q = 1'b1;
      addr_q = '0;
      wdata_q = '0;
      forever begin
         @(negedge clk);
         cmd_q = mem_cmd;
         addr_q = mem_addr;
         wdata_q = write_data;
         reset_q = reset;
      end
   end

   // Memory model, a write lands at its edge and read data follows one cycle after the address
   initial begin
      cpu_pkg::word_t want_addr;
      cpu_pkg::word_t want_data;
      read_data = '0;
      write_count = 0;
      forever begin
         @(posedge clk);
         #DRIVE_DELAY;
         if (!reset_q && cmd_q == cpu_pkg::MWRITE) begin
            mem[addr_q] = wdata_q;
            write_count++;
            if (exp_addr.size() == 0) begin
               $display("Unexpected memory write to address %0d in %s", addr_q, test_name);
               stop_on_failure();
            end else begin
               want_addr = exp_addr.pop_front();
               want_data = exp_data.pop_front();
               check_value("write address", want_addr, 16'(addr_q));
               check_value("write data", want_data, wdata_q);
            end
         end
         read_data = mem[addr_q];
      end
   end

   task automatic run_program(input bit need_round_trip);
      int round_trips;
      int first_write;
      if (!reset) begin
         @(posedge clk);
         #DRIVE_DELAY;
         reset = 1'b1;
      end
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = fill_word(i);
      end
      foreach (program_words[i]) begin
         mem[i] = program_words[i];
      end
      run_model(round_trips);
      if (need_round_trip && round_trips == 0) begin
         $display("No load in %s reads back a stored word", test_name);
         stop_on_failure();
      end
      first_write = write_count;
      repeat (2) @(posedge clk);
      #DRIVE_DELAY;
      reset = 1'b0;

      @(negedge clk);
      check_value("halt after reset", 16'd0, 16'(halt));
      check_value("mem_cmd after reset", 16'(cpu_pkg::MREAD), 16'(mem_cmd));
      check_value("mem_addr after reset", 16'd0, 16'(mem_addr));

      while (halt !== 1'b1) begin
         @(negedge clk);
      end
      repeat (HALT_HOLD) begin
         @(negedge clk);
         check_value("halt held high", 16'd1, 16'(halt));
      end
      check_value("write count", 16'(exp_count), 16'(write_count - first_write));
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      stop_on_failure();
   end

   initial begin
      reset = 1'b1;
      seed = 72812;
      test_name = "random program";
      build_random_program();
      run_program(1'b1);
      test_name = "unsupported opcode program";
      build_halt_program();
      run_program(1'b0);
      $display("All tests passed!");
      $finish;
   end

endmodule

/* build.f */
design/cpu_pkg.sv
design/cpu_ifs.sv
design/register_file.sv
design/datapath.sv
design/instruction_decoder.sv
design/address_unit.sv
design/cpu_controller.sv
design/cpu.sv
verification/tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_cpu
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_TEXT := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and look for the pass message"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
